// File: project.f
verilog/vram_video_pkg.sv
verilog/video_timing.sv
verilog/vram_fetch.sv
verilog/vram_port.sv
verilog/pixel_output.sv
verilog/vram_video_top.sv
verification/zbt_ram_model.sv
verification/tb_vram_video.sv

// File: run.sh
#!/bin/sh
# build and run the video testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_vram_video -f project.f -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

out=$(./obj_dir/sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "RESULT: PASS"; then
   exit 0
fi
exit 1

// File: verification/tb_vram_video.sv
// testbench for the frame buffer video top level
// small raster, ram model, reference functions, checker and watchdog
`timescale 1ns/100ps

module tb_vram_video;

   localparam int h_active = 32;
   localparam int h_sync_start = 36;
   localparam int h_sync_end = 44;
   localparam int h_total = 56;
   localparam int v_active = 8;
   localparam int v_sync_start = 9;
   localparam int v_sync_end = 10;
   localparam int v_total = 12;
   localparam int bar_shift = 2;
   localparam int frames = 6;
   localparam int run_cycles = frames * h_total * v_total;
   // twice the reset and the planned frames, 10 ns per cycle
   localparam int watchdog_ns = 2 * (run_cycles + 10) * 10;

   logic clk = 1'b0;
   logic rst;
   vram_video_pkg::pixel_source_e   mode_source;
   vram_video_pkg::pattern_period_e mode_period;
   vram_video_pkg::ram_req_t        ram_req;
   logic [35:0]                     ram_rdata;
   vram_video_pkg::vga_out_t        vga;

   // tb raster position, same as the DUT raster after reset
   int hc;
   int vc;
   int wr_cnt;
   logic [31:0] rng;
   // expected ram contents, built from the expected writes
   logic [35:0] shadow [logic [18:0]];
   // words read for the display, oldest first
   logic [35:0] fetched [$];
   logic [35:0] shown;
   vram_video_pkg::vga_out_t vga_exp;
   // test that owns the pixel check of the previous cycle, -1 for none
   int pix_test;
   int checks [5];
   int errors [5];
   string test_name [5] = '{"raster", "read slots", "writes", "display", "bars"};

   always #5 clk = ~clk;

   vram_video_top #(
      .h_active     (h_active),
      .h_sync_start (h_sync_start),
      .h_sync_end   (h_sync_end),
      .h_total      (h_total),
      .v_active     (v_active),
      .v_sync_start (v_sync_start),
      .v_sync_end   (v_sync_end),
      .v_total      (v_total),
      .bar_shift    (bar_shift)
   ) u_dut (
      .clk         (clk),
      .rst         (rst),
      .mode_source (mode_source),
      .mode_period (mode_period),
      .ram_req     (ram_req),
      .ram_rdata   (ram_rdata),
      .vga         (vga)
   );

   zbt_ram_model u_ram (
      .clk   (clk),
      .req   (ram_req),
      .rdata (ram_rdata)
   );

   ////////////////////////////////////////////////////////////
   // reference functions
   ////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic ref_hsync(input int h);
      return !(h >= h_sync_start && h < h_sync_end);
   endfunction

   function automatic logic ref_vsync(input int v);
      return !(v >= v_sync_start && v < v_sync_end);
   endfunction

   function automatic logic ref_blank(input int h, input int v);
      return (h >= h_active) || (v >= v_active);
   endfunction

   // word holding the pixel fetch_lead ahead, wrapping into the next line and frame
   function automatic logic [18:0] ref_read_addr(input int h, input int v);
      int hf;
      int vf;
      hf = h + vram_video_pkg::fetch_lead;
      vf = v;
      if (hf >= h_total) begin
         hf = hf - h_total;
         vf = (v + 1) % v_total;
      end
      return 19'(vf * (2 ** vram_video_pkg::hword_w) + hf / 4);
   endfunction

   // nibble from the pattern counter on top of every lane
   function automatic logic [35:0] ref_write_data(input int cnt,
                                                  input vram_video_pkg::pattern_period_e period);
      logic [3:0] nib;
      if (period == vram_video_pkg::period_16) begin
         nib = 4'((cnt >> 4) & 15);
      end else begin
         nib = 4'((cnt >> 3) & 15);
      end
      return {4{nib, 5'b00000}};
   endfunction

   function automatic logic [7:0] ref_bar(input int h);
      return {3'((h >> bar_shift) & 7), 5'b00000};
   endfunction

   // lane 3 holds the pixel with h%4 == 0, pixel is the upper 8 bits
   function automatic logic [7:0] lane_pixel(input logic [35:0] word, input int h);
      return word[(3 - h % 4) * 9 + 1 +: 8];
   endfunction

   task automatic check(input int test, input string name,
                        input logic [35:0] got, input logic [35:0] exp);
      checks[test]++;
      if (got !== exp) begin
         errors[test]++;
         $display("[FAIL] %0d ns %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // stimulus and compare, all on the falling edge
   ////////////////////////////////////////////////////////////

   initial begin
      logic        rd_exp;
      logic        wr_exp;
      logic [18:0] addr;
      logic [35:0] wd;
      int          total_checks;
      int          total_errors;
      rst = 1'b1;
      mode_source = vram_video_pkg::src_vram;
      mode_period = vram_video_pkg::period_8;
      rng = 32'd20;
      hc = 0;
      vc = 0;
      wr_cnt = 0;
      shown = '0;
      // the latch holds zero for the first two words after reset
      fetched.push_back('0);
      fetched.push_back('0);
      // reset values of the output register
      vga_exp.pixel = '0;
      vga_exp.hsync = 1'b1;
      vga_exp.vsync = 1'b1;
      vga_exp.blank = 1'b0;
      pix_test = 0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      for (int cyc = 0; cyc < run_cycles; cyc++) begin
         // vga shows the previous position
         check(0, "vga.hsync", 36'(vga.hsync), 36'(vga_exp.hsync));
         check(0, "vga.vsync", 36'(vga.vsync), 36'(vga_exp.vsync));
         check(0, "vga.blank", 36'(vga.blank), 36'(vga_exp.blank));
         if (pix_test >= 0) begin
            check(pix_test, "vga.pixel", 36'(vga.pixel), 36'(vga_exp.pixel));
         end
         // ram port for the current position
         rd_exp = (hc % 4 == 3);
         wr_exp = !rd_exp && ref_blank(hc, vc);
         check(1, "ram_req read", 36'(ram_req.valid && !ram_req.we), 36'(rd_exp));
         if (rd_exp) begin
            addr = ref_read_addr(hc, vc);
            check(1, "ram_req.addr", 36'(ram_req.addr), 36'(addr));
            fetched.push_back(shadow.exists(addr) ? shadow[addr] : '0);
         end
         check(2, "ram_req write", 36'(ram_req.valid && ram_req.we), 36'(wr_exp));
         if (wr_exp) begin
            wd = ref_write_data(wr_cnt, mode_period);
            check(2, "ram_req.addr", 36'(ram_req.addr), 36'(19'(wr_cnt)));
            check(2, "ram_req.wdata", ram_req.wdata, wd);
            shadow[19'(wr_cnt)] = wd;
            wr_cnt++;
         end
         // new modes at frame start, a cycle with no write
         if (hc == 0 && vc == 0 && cyc != 0) begin
            rng = xorshift(rng);
            mode_source = vram_video_pkg::pixel_source_e'(rng[0]);
            mode_period = vram_video_pkg::pattern_period_e'(rng[1]);
         end
         // expected output for this position, seen on the next cycle
         if (hc % 4 == 0) begin
            shown = fetched.pop_front();
         end
         vga_exp.hsync = ref_hsync(hc);
         vga_exp.vsync = ref_vsync(vc);
         vga_exp.blank = ref_blank(hc, vc);
         if (ref_blank(hc, vc)) begin
            pix_test = -1;
         end else if (mode_source == vram_video_pkg::src_bars) begin
            pix_test = 4;
            vga_exp.pixel = ref_bar(hc);
         end else begin
            pix_test = 3;
            vga_exp.pixel = lane_pixel(shown, hc);
         end
         hc++;
         if (hc == h_total) begin
            hc = 0;
            vc = (vc + 1) % v_total;
         end
         @(negedge clk);
      end
      total_checks = 0;
      total_errors = 0;
      for (int t = 0; t < 5; t++) begin
         if (checks[t] == 0) begin
            $display("%s test ran no checks", test_name[t]);
            errors[t]++;
         end
         $display("%s: %0d checks, %0d errors", test_name[t], checks[t], errors[t]);
         total_checks += checks[t];
         total_errors += errors[t];
      end
      $display("total: %0d checks, %0d errors", total_checks, total_errors);
      if (total_errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   // stops a run that never reaches the end of the frames
   initial begin
      #(watchdog_ns);
      $display("timeout after %0d ns, the run did not reach its end", watchdog_ns);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

// File: verification/zbt_ram_model.sv
// ram behaviour model for the frame buffer
// sparse storage that reads zero until written, read data two cycles after the request
`timescale 1ns/100ps

module zbt_ram_model (
   input  logic                              clk,
   input  vram_video_pkg::ram_req_t          req,
   output logic [vram_video_pkg::word_w-1:0] rdata
);

   // only the written words are stored
   logic [vram_video_pkg::word_w-1:0] mem [logic [vram_video_pkg::ram_addr_w-1:0]];
   logic [vram_video_pkg::word_w-1:0] stage1 = '0;
   logic [vram_video_pkg::word_w-1:0] stage2 = '0;

   always @(posedge clk) begin
      if (req.valid && req.we) begin
         mem[req.addr] = req.wdata;
      end
      // read pipeline, one register per cycle of latency
      if (req.valid && !req.we && mem.exists(req.addr)) begin
         stage1 <= mem[req.addr];
      end else begin
         stage1 <= '0;
      end
      stage2 <= stage1;
   end

   assign rdata = stage2;

endmodule

// File: verilog/vram_video_top.sv
// frame buffer video top level
// raster timing, display fetch, ram port and pixel output
`timescale 1ns/100ps

module vram_video_top #(
   parameter int h_active     = 1024,
   parameter int h_sync_start = 1048,
   parameter int h_sync_end   = 1184,
   parameter int h_total      = 1344,
   parameter int v_active     = 768,
   parameter int v_sync_start = 777,
   parameter int v_sync_end   = 783,
   parameter int v_total      = 806,
   parameter int bar_shift    = 6
) (
   input  logic                              clk,
   input  logic                              rst,
   input  vram_video_pkg::pixel_source_e     mode_source,
   input  vram_video_pkg::pattern_period_e   mode_period,
   output vram_video_pkg::ram_req_t          ram_req,
   input  logic [vram_video_pkg::word_w-1:0] ram_rdata,
   output vram_video_pkg::vga_out_t          vga
);

   vram_video_pkg::raster_t            raster;
   vram_video_pkg::ram_req_t           rd_req;
   logic [vram_video_pkg::pixel_w-1:0] vram_pixel;

   ////////////////////////////////////////////////////////////
   // raster and display fetch
   ////////////////////////////////////////////////////////////

   video_timing #(
      .h_active     (h_active),
      .h_sync_start (h_sync_start),
      .h_sync_end   (h_sync_end),
      .h_total      (h_total),
      .v_active     (v_active),
      .v_sync_start (v_sync_start),
      .v_sync_end   (v_sync_end),
      .v_total      (v_total)
   ) u_timing (
      .clk    (clk),
      .rst    (rst),
      .raster (raster)
   );

   // forecast needs the line and frame length for its wrap
   vram_fetch #(
      .h_total (h_total),
      .v_total (v_total)
   ) u_fetch (
      .clk        (clk),
      .rst        (rst),
      .raster     (raster),
      .ram_rdata  (ram_rdata),
      .rd_req     (rd_req),
      .vram_pixel (vram_pixel)
   );

   ////////////////////////////////////////////////////////////
   // ram port and output
   ////////////////////////////////////////////////////////////

   vram_port u_port (
      .clk         (clk),
      .rst         (rst),
      .raster      (raster),
      .mode_period (mode_period),
      .rd_req      (rd_req),
      .ram_req     (ram_req)
   );

   pixel_output #(
      .bar_shift (bar_shift)
   ) u_out (
      .clk         (clk),
      .rst         (rst),
      .raster      (raster),
      .mode_source (mode_source),
      .vram_pixel  (vram_pixel),
      .vga         (vga)
   );

endmodule

// File: verilog/pixel_output.sv
// pixel source select, grey bar generator and output register
`timescale 1ns/100ps

module pixel_output #(
   parameter int bar_shift = 6
) (
   input  logic                               clk,
   input  logic                               rst,
   input  vram_video_pkg::raster_t            raster,
   input  vram_video_pkg::pixel_source_e      mode_source,
   input  logic [vram_video_pkg::pixel_w-1:0] vram_pixel,
   output vram_video_pkg::vga_out_t           vga
);

   localparam int bar_bits = 3;

   logic [vram_video_pkg::pixel_w-1:0] bar_pixel;
   logic [vram_video_pkg::pixel_w-1:0] pixel_sel;

   // vertical bars straight from the pixel counter
   assign bar_pixel = {raster.hcount[bar_shift +: bar_bits],
                       {(vram_video_pkg::pixel_w - bar_bits){1'b0}}};

   assign pixel_sel = (mode_source == vram_video_pkg::src_bars) ? bar_pixel : vram_pixel;

   // pixel and syncs leave together, one cycle behind the raster
   always_ff @(posedge clk) begin
      if (rst) begin
         vga.pixel <= '0;
         vga.hsync <= 1'b1;
         vga.vsync <= 1'b1;
         vga.blank <= 1'b0;
      end else begin
         vga.pixel <= pixel_sel;
         vga.hsync <= raster.hsync;
         vga.vsync <= raster.vsync;
         vga.blank <= raster.blank;
      end
   end

endmodule

// File: verilog/vram_port.sv
// ram port owner
// merges display reads with pattern writes in the free blanking slots
`timescale 1ns/100ps

module vram_port (
   input  logic                            clk,
   input  logic                            rst,
   input  vram_video_pkg::raster_t         raster,
   input  vram_video_pkg::pattern_period_e mode_period,
   input  vram_video_pkg::ram_req_t        rd_req,
   output vram_video_pkg::ram_req_t        ram_req
);

   localparam int lanes    = vram_video_pkg::word_w / vram_video_pkg::lane_w;
   localparam int nibble_w = 4;

   logic [vram_video_pkg::ram_addr_w-1:0] pattern_cnt;
   logic [nibble_w-1:0]                   nibble;
   logic [vram_video_pkg::lane_w-1:0]     lane_data;
   logic                                  write_slot;

   // a slot is free when the display is not reading
   assign write_slot = ~rd_req.valid & raster.blank;

   ////////////////////////////////////////////////////////////
   // pattern data
   ////////////////////////////////////////////////////////////

   // bar period picked by which counter bits feed the nibble
   always_comb begin
      if (mode_period == vram_video_pkg::period_16) begin
         nibble = pattern_cnt[7:4];
      end else begin
         nibble = pattern_cnt[6:3];
      end
   end

   // nibble on top of each lane, rest zero
   assign lane_data = {nibble, {(vram_video_pkg::lane_w - nibble_w){1'b0}}};

   // write address, advances once per issued write and wraps
   always_ff @(posedge clk) begin
      if (rst) begin
         pattern_cnt <= '0;
      end else if (write_slot) begin
         pattern_cnt <= pattern_cnt + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // port merge
   ////////////////////////////////////////////////////////////

   always_comb begin
      ram_req = '0;
      if (rd_req.valid) begin
         // reads always win
         ram_req = rd_req;
      end else if (raster.blank) begin
         ram_req.valid = 1'b1;
         ram_req.we    = 1'b1;
         ram_req.addr  = pattern_cnt;
         ram_req.wdata = {lanes{lane_data}};
      end
   end

endmodule

// File: verilog/vram_fetch.sv
// display fetch from the frame buffer
// forecast read address, two-stage word latch, lane select
`timescale 1ns/100ps

module vram_fetch #(
   parameter int h_total = 1344,
   parameter int v_total = 806
) (
   input  logic                                   clk,
   input  logic                                   rst,
   input  vram_video_pkg::raster_t                raster,
   input  logic [vram_video_pkg::word_w-1:0]      ram_rdata,
   output vram_video_pkg::ram_req_t               rd_req,
   output logic [vram_video_pkg::pixel_w-1:0]     vram_pixel
);

   typedef logic [vram_video_pkg::hcount_w-1:0] hcnt_t;
   typedef logic [vram_video_pkg::vcount_w-1:0] vcnt_t;

   localparam hcnt_t lead       = hcnt_t'(vram_video_pkg::fetch_lead);
   // first hcount whose forecast falls on the next line
   localparam hcnt_t wrap_point = hcnt_t'(h_total - vram_video_pkg::fetch_lead);
   localparam vcnt_t v_last     = vcnt_t'(v_total - 1);
   // one read per word, in the last pixel slot of the word
   localparam logic [1:0] read_slot  = 2'd3;
   // read data comes back ram_latency cycles later
   localparam logic [1:0] latch_slot = read_slot + 2'(vram_video_pkg::ram_latency);
   localparam int lane_w  = vram_video_pkg::lane_w;
   localparam int pixel_w = vram_video_pkg::pixel_w;

   logic [1:0]                        hc4;
   logic                              h_wrap;
   hcnt_t                             hcount_f;
   vcnt_t                             vcount_f;
   logic [vram_video_pkg::word_w-1:0] word_latched;
   logic [vram_video_pkg::word_w-1:0] word_shown;
   logic [1:0]                        lane_sel;

   assign hc4 = raster.hcount[1:0];

   ////////////////////////////////////////////////////////////
   // forecast position, fetch_lead pixels ahead
   ////////////////////////////////////////////////////////////

   assign h_wrap   = (raster.hcount >= wrap_point);
   assign hcount_f = h_wrap ? raster.hcount - wrap_point : raster.hcount + lead;

   always_comb begin
      vcount_f = raster.vcount;
      // forecast runs into the next line, or line 0 after the last
      if (h_wrap) begin
         vcount_f = (raster.vcount == v_last) ? '0 : raster.vcount + 1'b1;
      end
   end

   // read request, address is {line, word within line}
   always_comb begin
      rd_req       = '0;
      rd_req.valid = (hc4 == read_slot);
      rd_req.we    = 1'b0;
      rd_req.addr  = {vcount_f, hcount_f[vram_video_pkg::hcount_w-1 -: vram_video_pkg::hword_w]};
   end

   ////////////////////////////////////////////////////////////
   // two-stage latch
   ////////////////////////////////////////////////////////////

   // stage 1 catches the word as it leaves the ram,
   // stage 2 holds it for the whole four-pixel window
   always_ff @(posedge clk) begin
      if (rst) begin
         word_latched <= '0;
         word_shown   <= '0;
      end else begin
         if (hc4 == latch_slot) begin
            word_latched <= ram_rdata;
         end
         if (hc4 == read_slot) begin
            word_shown <= word_latched;
         end
      end
   end

   // hcount%4 == 0 picks lane 3, the top one
   assign lane_sel   = ~hc4;
   assign vram_pixel = word_shown[lane_sel * lane_w + (lane_w - pixel_w) +: pixel_w];

endmodule

// File: verilog/video_timing.sv
// raster generator
// horizontal and vertical counters, active-low syncs and blank
`timescale 1ns/100ps

module video_timing #(
   parameter int h_active     = 1024,
   parameter int h_sync_start = 1048,
   parameter int h_sync_end   = 1184,
   parameter int h_total      = 1344,
   parameter int v_active     = 768,
   parameter int v_sync_start = 777,
   parameter int v_sync_end   = 783,
   parameter int v_total      = 806
) (
   input  logic                    clk,
   input  logic                    rst,
   output vram_video_pkg::raster_t raster
);

   typedef logic [vram_video_pkg::hcount_w-1:0] hcnt_t;
   typedef logic [vram_video_pkg::vcount_w-1:0] vcnt_t;

   // timing points at counter width
   localparam hcnt_t h_last     = hcnt_t'(h_total - 1);
   localparam hcnt_t h_act      = hcnt_t'(h_active);
   localparam hcnt_t h_sync_on  = hcnt_t'(h_sync_start);
   localparam hcnt_t h_sync_off = hcnt_t'(h_sync_end);
   localparam vcnt_t v_last     = vcnt_t'(v_total - 1);
   localparam vcnt_t v_act      = vcnt_t'(v_active);
   localparam vcnt_t v_sync_on  = vcnt_t'(v_sync_start);
   localparam vcnt_t v_sync_off = vcnt_t'(v_sync_end);

   logic  h_wrap;
   hcnt_t hcount_next;
   vcnt_t vcount_next;
   logic  hblank_next;
   logic  vblank_next;
   logic  hsync_next;
   logic  vsync_next;

   ////////////////////////////////////////////////////////////
   // next position
   ////////////////////////////////////////////////////////////

   // end of line
   assign h_wrap      = (raster.hcount == h_last);
   assign hcount_next = h_wrap ? '0 : raster.hcount + 1'b1;

   always_comb begin
      vcount_next = raster.vcount;
      // new line, wrap to line 0 after the last one
      if (h_wrap) begin
         vcount_next = (raster.vcount == v_last) ? '0 : raster.vcount + 1'b1;
      end
   end

   // syncs and blank decoded from the next position,
   // so they land on the same edge as the counters
   assign hblank_next = (hcount_next >= h_act);
   assign vblank_next = (vcount_next >= v_act);
   assign hsync_next  = ~((hcount_next >= h_sync_on) && (hcount_next < h_sync_off));
   assign vsync_next  = ~((vcount_next >= v_sync_on) && (vcount_next < v_sync_off));

   ////////////////////////////////////////////////////////////
   // raster registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         raster.hcount <= '0;
         raster.vcount <= '0;
         raster.hsync  <= 1'b1;
         raster.vsync  <= 1'b1;
         raster.blank  <= 1'b0;
      end else begin
         raster.hcount <= hcount_next;
         raster.vcount <= vcount_next;
         raster.hsync  <= hsync_next;
         raster.vsync  <= vsync_next;
         raster.blank  <= hblank_next | vblank_next;
      end
   end

endmodule

// File: verilog/vram_video_pkg.sv
// widths, ram lane layout, mode enums and bus structs
// shared by the frame buffer video path
package vram_video_pkg;

   ////////////////////////////////////////////////////////////
   // widths
   ////////////////////////////////////////////////////////////

   // raster counters
   localparam int hcount_w = 11;
   localparam int vcount_w = 10;
   // one ram word is four 9-bit lanes
   localparam int word_w = 36;
   // lane 3 (top bits) holds the pixel at hcount%4 == 0, lane 0 the one at 3
   localparam int lane_w = 9;
   // grey pixel is the upper 8 bits of its lane
   localparam int pixel_w = 8;
   // word index within a line, four pixels per word
   localparam int hword_w = hcount_w - 2;
   // address is {vcount, hcount / 4}
   localparam int ram_addr_w = 19;
   // display side reads this many pixels ahead
   localparam int fetch_lead = 8;
   // cycles from read request to read data
   localparam int ram_latency = 2;

   ////////////////////////////////////////////////////////////
   // modes and buses
   ////////////////////////////////////////////////////////////

   typedef enum logic {src_vram, src_bars} pixel_source_e;
   typedef enum logic {period_8, period_16} pattern_period_e;

   // raster position, syncs active low
   typedef struct packed {
      logic [hcount_w-1:0] hcount;
      logic [vcount_w-1:0] vcount;
      logic                hsync;
      logic                vsync;
      logic                blank;
   } raster_t;

   // one request per cycle, no handshake
   typedef struct packed {
      logic                  valid;
      logic                  we;
      logic [ram_addr_w-1:0] addr;
      logic [word_w-1:0]     wdata;
   } ram_req_t;

   typedef struct packed {
      logic [pixel_w-1:0] pixel;
      logic               hsync;
      logic               vsync;
      logic               blank;
   } vga_out_t;

endpackage
